// File: common/nfcDataInPkg.sv
`default_nettype none

package nfcDataInPkg;

    localparam int BeatWidth     = 16;  // two bytes per beat
    localparam int CountWidth    = 16;
    localparam int PinGroupWidth = 4;
    localparam int TimerWidth    = 4;

    // tCAD / tDQSS
    localparam logic [TimerWidth-1:0] PreambleCycles  = TimerWidth'(3);
    // tCKWR / tWPST
    localparam logic [TimerWidth-1:0] PostambleCycles = TimerWidth'(3);

    // read enable and latch enable pin codes
    localparam logic [PinGroupWidth-1:0] ReadEnableIdle   = 4'b0011;
    localparam logic [PinGroupWidth-1:0] ReadEnableActive = 4'b0000;
    localparam logic [PinGroupWidth-1:0] LatchEnableIdle  = 4'b0000;
    localparam logic [PinGroupWidth-1:0] LatchEnableData  = 4'b0011;  // data input pattern

    // burst phases, one-hot
    typedef enum logic [6:0] {
        sReset      = 7'b000_0001,
        sReady      = 7'b000_0010,
        sLatch      = 7'b000_0100,
        sPreamble   = 7'b000_1000,
        sWaitBuffer = 7'b001_0000,
        sTransfer   = 7'b010_0000,
        sPostamble  = 7'b100_0000
    } phaseT;

    typedef enum logic [PinGroupWidth-1:0] {
        weIdle  = 4'b0011,  // reset only
        weValid = 4'b0010
    } writeEnableT;

    // pins shared by all ways
    typedef struct packed {
        logic [PinGroupWidth-1:0] readEnable;
        writeEnableT              writeEnable;
        logic [PinGroupWidth-1:0] addressLatchEnable;
        logic [PinGroupWidth-1:0] commandLatchEnable;
        logic                     dqsOutEnable;
        logic                     dqOutEnable;
    } pinCtrlT;

    typedef struct packed {
        logic [BeatWidth-1:0] data;
        logic                 last;
    } streamBeatT;

endpackage

`default_nettype wire

// File: dataInSequencer/phaseSequencer.sv
`default_nettype none
`timescale 1ns/100ps

module phaseSequencer #(
    parameter int numberOfWays = 4
) (
    input  logic                                iSystemClock,
    input  logic                                rstN,

    input  logic                                start,
    input  logic [numberOfWays-1:0]             targetWay,
    input  logic [nfcDataInPkg::CountWidth-1:0] numOfData,
    input  logic                                bufferReady,

    output nfcDataInPkg::phaseT                 nextPhase,
    output logic                                postambleHold,
    output logic [numberOfWays-1:0]             latchedWay,
    output logic                                ready,
    output logic                                lastStep
);
    import nfcDataInPkg::*;

    phaseT                    phase;
    logic [CountWidth-1:0]    latchedCount;
    logic [CountWidth-1:0]    byteCount;
    logic [TimerWidth-1:0]    timer;
    logic                     preambleDone;
    logic                     postambleDone;
    logic                     countDone;

    assign preambleDone  = (timer == PreambleCycles);
    assign postambleDone = (timer == PostambleCycles);
    assign countDone     = (byteCount == latchedCount);
    assign postambleHold = (timer < PostambleCycles);

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            phase <= sReset;
        end else begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        case (phase)
            sReset:      nextPhase = sReady;
            sReady:      nextPhase = start ? sLatch : sReady;
            sLatch:      nextPhase = sPreamble;
            sPreamble:   nextPhase = preambleDone ? sWaitBuffer : sPreamble;
            sWaitBuffer: nextPhase = bufferReady ? sTransfer : sWaitBuffer;
            sTransfer:   nextPhase = countDone ? sPostamble : sTransfer;
            sPostamble:  nextPhase = lastStep ? sReady : sPostamble;
            default:     nextPhase = sReady;
        endcase
    end

    // request is captured once, on entry to the latch phase
    always_ff @(posedge iSystemClock) begin
        if (nextPhase == sLatch) begin
            latchedWay   <= ~targetWay;  // chip enable is active low
            latchedCount <= numOfData;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            ready    <= 1'b0;
            lastStep <= 1'b0;
        end else begin
            ready    <= (nextPhase == sReady);
            lastStep <= (nextPhase == sPostamble) && postambleDone && countDone;
        end
    end

    // phase timer restarts on entry to preamble and postamble
    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            timer <= '0;
        end else begin
            case (nextPhase)
                sPreamble,
                sPostamble: timer <= (phase == nextPhase) ? timer + 1'b1 : '0;
                default:    timer <= '0;
            endcase
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            byteCount <= '0;
        end else begin
            case (nextPhase)
                sTransfer:   byteCount <= byteCount + CountWidth'(2);  // two bytes a cycle
                sWaitBuffer,
                sPostamble:  byteCount <= byteCount;
                default:     byteCount <= '0;
            endcase
        end
    end

    nextPhaseOneHot: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        $onehot(nextPhase)
    );

    // counter steps by two, so an odd or zero count never terminates
    legalByteCount: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        start |-> ((numOfData != '0) && !numOfData[0])
    );

    lastStepSingle: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        lastStep |=> !lastStep
    );

endmodule

`default_nettype wire

// File: dataInSequencer/busPinEncoder.sv
`default_nettype none
`timescale 1ns/100ps

module busPinEncoder #(
    parameter int numberOfWays = 4
) (
    input  logic                      iSystemClock,
    input  logic                      rstN,

    input  nfcDataInPkg::phaseT       nextPhase,
    input  logic                      postambleHold,
    input  logic [numberOfWays-1:0]   latchedWay,

    output nfcDataInPkg::pinCtrlT     pins,
    output logic [2*numberOfWays-1:0] chipEnable
);
    import nfcDataInPkg::*;

    localparam pinCtrlT ResetPins = '{
        readEnable:         ReadEnableIdle,
        writeEnable:        weIdle,
        addressLatchEnable: LatchEnableIdle,
        commandLatchEnable: LatchEnableIdle,
        dqsOutEnable:       1'b0,
        dqOutEnable:        1'b0
    };

    pinCtrlT                    pinsNext;
    logic [2*numberOfWays-1:0]  chipEnableNext;

    always_comb begin
        pinsNext             = ResetPins;
        pinsNext.writeEnable = weValid;
        chipEnableNext       = '1;  // all ways deselected
        case (nextPhase)
            sReset: begin
                pinsNext.writeEnable = weIdle;
            end
            sPreamble: begin
                chipEnableNext      = {latchedWay, latchedWay};
                pinsNext.readEnable = ReadEnableActive;
            end
            sWaitBuffer,
            sTransfer: begin
                chipEnableNext        = {latchedWay, latchedWay};
                pinsNext.readEnable   = ReadEnableActive;
                pinsNext.dqsOutEnable = 1'b1;
                pinsNext.dqOutEnable  = 1'b1;
                if (nextPhase == sTransfer) begin
                    pinsNext.addressLatchEnable = LatchEnableData;
                    pinsNext.commandLatchEnable = LatchEnableData;
                end
            end
            sPostamble: begin
                // ways released once the hold time has passed
                chipEnableNext        = postambleHold ? {latchedWay, latchedWay} : '0;
                pinsNext.readEnable   = postambleHold ? ReadEnableActive : ReadEnableIdle;
                pinsNext.dqsOutEnable = 1'b1;
                pinsNext.dqOutEnable  = 1'b1;
            end
            default: ;  // ready and latch stay idle
        endcase
    end

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            pins       <= ResetPins;
            chipEnable <= '1;
        end else begin
            pins       <= pinsNext;
            chipEnable <= chipEnableNext;
        end
    end

    aleOnlyInTransfer: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        (pins.addressLatchEnable != LatchEnableIdle) |-> ($past(nextPhase) == sTransfer)
    );

endmodule

`default_nettype wire

// File: hw/beatFifo.sv
`default_nettype none
`timescale 1ns/100ps

module beatFifo #(
    parameter int fifoDepth = 16  // power of two
) (
    input  logic                     iSystemClock,
    input  logic                     rstN,

    input  nfcDataInPkg::streamBeatT writeBeat,
    input  logic                     writeValid,
    output logic                     writeReady,

    output nfcDataInPkg::streamBeatT readBeat,
    output logic                     readValid,
    input  logic                     readReady
);
    import nfcDataInPkg::*;

    localparam int IndexWidth = $clog2(fifoDepth);

    streamBeatT            mem [fifoDepth];
    logic [IndexWidth:0]   wrPtr;   // extra bit tells full from empty
    logic [IndexWidth:0]   rdPtr;
    logic [IndexWidth:0]   rdPtrNext;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full = (wrPtr[IndexWidth] != rdPtr[IndexWidth])
               && (wrPtr[IndexWidth-1:0] == rdPtr[IndexWidth-1:0]);

    assign writeReady = !full;
    assign push       = writeValid && !full;
    assign pop        = readValid && readReady;
    assign rdPtrNext  = pop ? rdPtr + 1'b1 : rdPtr;

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            wrPtr <= '0;
        end else if (push) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (push) begin
            mem[wrPtr[IndexWidth-1:0]] <= writeBeat;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            rdPtr     <= '0;
            readValid <= 1'b0;
        end else begin
            rdPtr     <= rdPtrNext;
            readValid <= (wrPtr != rdPtrNext);  // beat written last cycle is visible now
        end
    end

    // head register holds while not popped
    always_ff @(posedge iSystemClock) begin
        readBeat <= mem[rdPtrNext[IndexWidth-1:0]];
    end

    // occupancy never exceeds the depth
    noWriteWhenFull: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        (IndexWidth+1)'(wrPtr - rdPtr) <= (IndexWidth+1)'(fifoDepth)
    );

endmodule

`default_nettype wire

// File: hw/nfcDataInSync.sv
`default_nettype none
`timescale 1ns/100ps

module nfcDataInSync #(
    parameter int numberOfWays = 4,
    parameter int fifoDepth    = 16
) (
    input  logic                                iSystemClock,
    input  logic                                rstN,

    input  logic                                start,
    input  logic [numberOfWays-1:0]             targetWay,
    input  logic [nfcDataInPkg::CountWidth-1:0] numOfData,
    output logic                                ready,
    output logic                                lastStep,

    input  nfcDataInPkg::streamBeatT            writeBeat,
    input  logic                                writeValid,
    output logic                                writeReady,

    output nfcDataInPkg::streamBeatT            readBeat,
    output logic                                readValid,
    input  logic                                readReady,

    output nfcDataInPkg::pinCtrlT               pins,
    output logic [2*numberOfWays-1:0]           chipEnable
);
    import nfcDataInPkg::*;

    phaseT                    nextPhase;
    logic                     postambleHold;
    logic [numberOfWays-1:0]  latchedWay;

    phaseSequencer #(
        .numberOfWays (numberOfWays)
    ) i_phaseSequencer (
        .iSystemClock  (iSystemClock),
        .rstN          (rstN),
        .start         (start),
        .targetWay     (targetWay),
        .numOfData     (numOfData),
        .bufferReady   (writeReady),  // transfer waits on buffer space
        .nextPhase     (nextPhase),
        .postambleHold (postambleHold),
        .latchedWay    (latchedWay),
        .ready         (ready),
        .lastStep      (lastStep)
    );

    busPinEncoder #(
        .numberOfWays (numberOfWays)
    ) i_busPinEncoder (
        .iSystemClock  (iSystemClock),
        .rstN          (rstN),
        .nextPhase     (nextPhase),
        .postambleHold (postambleHold),
        .latchedWay    (latchedWay),
        .pins          (pins),
        .chipEnable    (chipEnable)
    );

    beatFifo #(
        .fifoDepth (fifoDepth)
    ) i_beatFifo (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .writeBeat    (writeBeat),
        .writeValid   (writeValid),
        .writeReady   (writeReady),
        .readBeat     (readBeat),
        .readValid    (readValid),
        .readReady    (readReady)
    );

endmodule

`default_nettype wire

// File: verif/tbClockGen.sv
`default_nettype none
`timescale 1ns/100ps

module tbClockGen #(
    parameter int halfPeriod  = 10,  // 20 ns clock
    parameter int resetCycles = 3
) (
    output logic iSystemClock,
    output logic rstN
);

    initial begin
        iSystemClock = 1'b0;
        forever #(halfPeriod) iSystemClock = ~iSystemClock;
    end

    // reset released on a falling edge, like the other inputs
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge iSystemClock);
        @(negedge iSystemClock);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tbNfcDataInSync.sv
`default_nettype none
`timescale 1ns/100ps

module tbNfcDataInSync;
    import nfcDataInPkg::*;

    localparam int Ways  = 4;
    localparam int Depth = 16;
    // 12 bursts of under 40 cycles and a few hundred FIFO cycles fit easily
    localparam int CycleLimit = 20000;

    logic                   iSystemClock;
    logic                   rstN;
    logic                   start;
    logic [Ways-1:0]        targetWay;
    logic [CountWidth-1:0]  numOfData;
    logic                   ready;
    logic                   lastStep;
    streamBeatT             writeBeat;
    logic                   writeValid;
    logic                   writeReady;
    streamBeatT             readBeat;
    logic                   readValid;
    logic                   readReady;
    pinCtrlT                pins;
    logic [2*Ways-1:0]      chipEnable;

    phaseT                  expPhase;
    logic                   expHold;
    logic                   expLast;
    logic [Ways-1:0]        expWay;
    logic                   checkOn;
    streamBeatT             scoreboard[$];
    int                     pushCount;
    int                     aleCycles;
    int                     waitCycles;
    int                     cycleCount;
    int                     errorCount;
    logic [31:0]            lfsr;

    tbClockGen i_tbClockGen (
        .iSystemClock (iSystemClock),
        .rstN         (rstN)
    );

    nfcDataInSync #(
        .numberOfWays (Ways),
        .fifoDepth    (Depth)
    ) i_nfcDataInSync (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .start        (start),
        .targetWay    (targetWay),
        .numOfData    (numOfData),
        .ready        (ready),
        .lastStep     (lastStep),
        .writeBeat    (writeBeat),
        .writeValid   (writeValid),
        .writeReady   (writeReady),
        .readBeat     (readBeat),
        .readValid    (readValid),
        .readReady    (readReady),
        .pins         (pins),
        .chipEnable   (chipEnable)
    );

    // fibonacci lfsr on taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic pinCtrlT expectedPins(input phaseT p, input logic hold);
        pinCtrlT e;
        e.readEnable         = 4'b0011;
        e.writeEnable        = weValid;
        e.addressLatchEnable = 4'b0000;
        e.commandLatchEnable = 4'b0000;
        e.dqsOutEnable       = 1'b0;
        e.dqOutEnable        = 1'b0;
        case (p)
            sReset:    e.writeEnable = weIdle;
            sPreamble: e.readEnable = 4'b0000;
            sWaitBuffer, sTransfer, sPostamble: begin
                e.readEnable   = (p == sPostamble && !hold) ? 4'b0011 : 4'b0000;
                e.dqsOutEnable = 1'b1;
                e.dqOutEnable  = 1'b1;
                if (p == sTransfer) begin
                    e.addressLatchEnable = 4'b0011;
                    e.commandLatchEnable = 4'b0011;
                end
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic logic [2*Ways-1:0] expectedChipEnable(input phaseT p, input logic hold,
                                                              input logic [Ways-1:0] way);
        case (p)
            sPreamble, sWaitBuffer, sTransfer: return {way, way};
            sPostamble: return hold ? {way, way} : '0;
            default:    return '1;
        endcase
    endfunction

    task automatic failNow(input string what);
        errorCount++;
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkPins(input string name, input pinCtrlT act, input pinCtrlT exp);
        if (act !== exp) begin
            failNow($sformatf("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic checkChipEnable(input string name, input logic [2*Ways-1:0] act,
                                   input logic [2*Ways-1:0] exp);
        if (act !== exp) begin
            failNow($sformatf("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic checkBeat(input string name, input streamBeatT act, input streamBeatT exp);
        if (act !== exp) begin
            failNow($sformatf("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic checkBit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            failNow($sformatf("ERROR time=%0t %s expected=%b actual=%b", $time, name, exp, act));
        end
    endtask

    // outputs are compared on the edge that ends the cycle they were stable in
    always @(posedge iSystemClock) begin
        if (checkOn) begin
            checkPins("pins", pins, expectedPins(expPhase, expHold));
            checkChipEnable("chipEnable", chipEnable,
                            expectedChipEnable(expPhase, expHold, expWay));
            checkBit("ready", ready, expPhase == sReady);
            checkBit("lastStep", lastStep, expLast);
            if (pins.addressLatchEnable == 4'b0011) aleCycles++;
            if (readValid && readReady) begin
                if (scoreboard.size() == 0) begin
                    failNow("read handshake while the FIFO model holds no beat");
                end else begin
                    checkBeat("readBeat", readBeat, scoreboard.pop_front());
                end
            end
            if (writeValid && writeReady) begin
                scoreboard.push_back(writeBeat);
                pushCount++;
            end
        end
    end

    always @(posedge iSystemClock) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic holdPhase(input phaseT p, input logic hold, input logic last);
        expPhase = p;
        expHold  = hold;
        expLast  = last;
        @(negedge iSystemClock);
    endtask

    task automatic drawBurst(output logic [Ways-1:0] way, output int count);
        logic [31:0] r;
        r   = randBits(Ways);
        way = (r[Ways-1:0] == '0) ? Ways'(1) : r[Ways-1:0];
        r   = randBits(4);
        count = (int'(r[3:0]) + 1) * 2;  // even count from 2 to 32
    endtask

    task automatic runBurst(input logic [Ways-1:0] way, input int count);
        logic bufferFree;
        start     = 1'b1;
        targetWay = way;
        numOfData = CountWidth'(count);
        holdPhase(sReady, 1'b1, 1'b0);
        start      = 1'b0;
        expWay     = ~way;
        aleCycles  = 0;
        waitCycles = 0;
        holdPhase(sLatch, 1'b1, 1'b0);
        repeat (4) holdPhase(sPreamble, 1'b1, 1'b0);
        do begin
            bufferFree = writeReady;
            waitCycles++;
            holdPhase(sWaitBuffer, 1'b1, 1'b0);
        end while (!bufferFree);
        repeat (count / 2) holdPhase(sTransfer, 1'b1, 1'b0);
        repeat (4) holdPhase(sPostamble, 1'b1, 1'b0);
        holdPhase(sPostamble, 1'b0, 1'b1);
        if (aleCycles != count / 2) begin
            failNow($sformatf("burst of %0d bytes had %0d data cycles", count, aleCycles));
        end
        expPhase = sReady;
        expLast  = 1'b0;
    endtask

    task automatic streamRandomBeats(input int count);
        logic [31:0] r;
        int          target;
        target = pushCount + count;
        while (pushCount < target) begin
            r               = randBits(19);
            writeValid      = r[18];
            readReady       = r[17];
            writeBeat.last  = r[16];
            writeBeat.data  = r[15:0];
            @(negedge iSystemClock);
        end
        writeValid = 1'b0;
    endtask

    task automatic fillFifo();
        logic [31:0] r;
        int          target;
        target     = pushCount + Depth;
        readReady  = 1'b0;
        writeValid = 1'b1;
        while (pushCount < target) begin
            r         = randBits(17);
            writeBeat = streamBeatT'(r[16:0]);
            @(negedge iSystemClock);
        end
        writeValid = 1'b0;
    endtask

    task automatic drainFifo();
        writeValid = 1'b0;
        readReady  = 1'b1;
        while (scoreboard.size() != 0) @(negedge iSystemClock);
        checkBit("readValid", readValid, 1'b0);
        readReady = 1'b0;
    endtask

    task automatic freeOneBeat();
        repeat (10) @(negedge iSystemClock);
        readReady = 1'b1;
        @(negedge iSystemClock);
        readReady = 1'b0;
    endtask

    initial begin
        logic [Ways-1:0] way;
        logic [Ways-1:0] wayList [3];
        int              count;
        int              countList [3];
        int              b;
        start      = 1'b0;
        targetWay  = '0;
        numOfData  = CountWidth'(2);
        writeBeat  = '0;
        writeValid = 1'b0;
        readReady  = 1'b0;
        expPhase   = sReset;
        expHold    = 1'b1;
        expLast    = 1'b0;
        expWay     = '1;
        checkOn    = 1'b0;
        pushCount  = 0;
        aleCycles  = 0;
        waitCycles = 0;
        cycleCount = 0;
        errorCount = 0;
        lfsr       = 32'hb7c8_7963;

        @(posedge rstN);
        checkOn = 1'b1;
        holdPhase(sReset, 1'b1, 1'b0);
        repeat (3) holdPhase(sReady, 1'b1, 1'b0);

        for (b = 0; b < 8; b++) begin
            drawBurst(way, count);
            runBurst(way, count);
            repeat (2) holdPhase(sReady, 1'b1, 1'b0);
        end

        for (b = 0; b < 3; b++) begin
            drawBurst(wayList[b], countList[b]);
        end
        fork
            streamRandomBeats(60);
            begin
                for (int k = 0; k < 3; k++) begin
                    runBurst(wayList[k], countList[k]);
                end
            end
        join
        drainFifo();

        fillFifo();
        checkBit("writeReady", writeReady, 1'b0);
        drawBurst(way, count);
        fork
            runBurst(way, count);
            freeOneBeat();
        join
        if (waitCycles < 2) begin
            failNow("burst did not wait for space in the full FIFO");
        end
        drainFifo();
        repeat (2) holdPhase(sReady, 1'b1, 1'b0);

        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: nfcDataInSync.f
common/nfcDataInPkg.sv
dataInSequencer/phaseSequencer.sv
dataInSequencer/busPinEncoder.sv
hw/beatFifo.sv
hw/nfcDataInSync.sv
verif/tbClockGen.sv
verif/tbNfcDataInSync.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbNfcDataInSync
FILELIST = nfcDataInSync.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
